/* common/scope_defs.svh */
`ifndef SCOPE_DEFS_SVH
`define SCOPE_DEFS_SVH

// sample stream
`define SCOPE_DW   14  // sample width

// decimation
`define SCOPE_DCW  17  // decimation counter width
`define SCOPE_DSW   4  // averaging shift width

// acquisition
`define SCOPE_CW   32  // pre/post counter width
`define SCOPE_TW   64  // timestamp width
`define SCOPE_TN    4  // trigger sources

// system bus
`define SCOPE_BAW   7  // decoded address bits
`define SCOPE_BDW  32  // data word, address is as wide

`endif

/* common/scope_pkg.sv */
`default_nettype none

`include "scope_defs.svh"

package scope_pkg;

  // sample path
  typedef logic signed [`SCOPE_DW-1:0]            sample_t;
  typedef logic        [`SCOPE_DCW-1:0]           dec_t;    // decimation factor
  typedef logic        [`SCOPE_DSW-1:0]           shr_t;    // averaging shift
  // group sum, wide enough for 2**DCW samples
  typedef logic signed [`SCOPE_DW+`SCOPE_DCW-1:0] acc_t;

  // acquisition
  typedef logic [`SCOPE_CW-1:0] cnt_t;
  typedef logic [`SCOPE_TW-1:0] stamp_t;
  typedef logic [`SCOPE_TN-1:0] trg_t;    // select mask and source vector

  // system bus
  typedef logic [`SCOPE_BDW-1:0] bus_addr_t;
  typedef logic [`SCOPE_BDW-1:0] bus_data_t;

  // acquisition sequence
  typedef enum logic [1:0] {
    idle,   // stream sunk
    pre,    // filling pre-trigger count
    armed,  // waiting for trigger
    post    // counting post-trigger samples
  } acq_state_t;

endpackage

`default_nettype wire

/* project.f */
+incdir+common
common/scope_pkg.sv
src/scope_regs.sv
src/scope_dec_avg.sv
src/scope_edge.sv
src/scope_acq.sv
src/scope_top.sv
tb/scope_props.sv
tb/scope_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the scope testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module scope_tb -Mdir obj_dir -o scope_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/scope_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q '>>> FAIL' sim.log; then
  echo "testbench reported failure, see sim.log"
  exit 1
fi

if ! grep -q '>>> PASS' sim.log; then
  echo "testbench did not finish, see sim.log"
  exit 1
fi

exit 0

/* src/scope_acq.sv */
`timescale 1ns/1ns
`default_nettype none

module scope_acq (
  input  logic               bus,
  input  logic               reset,
  // control
  input  logic               ctl_rst,
  input  logic               ctl_acq,
  input  logic               ctl_stp,
  // triggers
  input  scope_pkg::trg_t    cfg_trg,  // source mask
  input  scope_pkg::trg_t    trg_src,
  // counts
  input  scope_pkg::cnt_t    cfg_pre,
  input  scope_pkg::cnt_t    cfg_pst,
  // free running time
  input  scope_pkg::stamp_t  cts,
  // decimated stream in
  input  scope_pkg::sample_t sti_data,
  input  logic               sti_valid,
  output logic               sti_ready,
  // captured stream out
  output scope_pkg::sample_t sto_data,
  output logic               sto_last,
  output logic               sto_valid,
  input  logic               sto_ready,
  // status
  output logic               sts_acq,
  output logic               sts_trg,
  output scope_pkg::cnt_t    sts_pre,
  output scope_pkg::cnt_t    sts_pst,
  output scope_pkg::stamp_t  cts_acq,
  output scope_pkg::stamp_t  cts_trg,
  output scope_pkg::stamp_t  cts_stp,
  // interrupts
  output logic               irq_trg,
  output logic               irq_stp
);

  import scope_pkg::*;

  acq_state_t state;
  logic       xfer;      // forwarded transfer
  logic       trg;       // any selected source active
  logic       ev_acq;    // start accepted
  logic       ev_trg;    // trigger accepted in armed
  logic       ev_end;    // last post sample transferred
  logic       ev_abort;  // software stop while running
  logic       ev_stp;

  ////////////////////////////////////////////////////////////
  // stream gating
  ////////////////////////////////////////////////////////////

  assign sts_acq   = (state != idle);
  assign sto_data  = sti_data;
  assign sto_valid = sti_valid & sts_acq;
  assign sti_ready = ~sts_acq | sto_ready;  // idle sinks everything
  assign xfer      = sto_valid & sto_ready;

  // the transfer that brings sts_pst up to cfg_pst
  assign sto_last = sto_valid & (state == post) & (sts_pst + 1'b1 == cfg_pst);

  ////////////////////////////////////////////////////////////
  // events, stop wins over start
  ////////////////////////////////////////////////////////////

  assign trg      = |(cfg_trg & trg_src);
  assign ev_abort = ctl_stp & sts_acq;
  assign ev_acq   = ctl_acq & ~ctl_stp;
  assign ev_trg   = (state == armed) & trg & ~ctl_stp & ~ctl_acq;
  assign ev_end   = sto_last & sto_ready & ~ctl_stp & ~ctl_acq;
  assign ev_stp   = ev_abort | ev_end;

  ////////////////////////////////////////////////////////////
  // FSM and counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset || ctl_rst) begin
      state   <= idle;
      sts_trg <= 1'b0;
      sts_pre <= '0;
      sts_pst <= '0;
      irq_trg <= 1'b0;
      irq_stp <= 1'b0;
    end else begin
      irq_trg <= ev_trg;
      irq_stp <= ev_stp;
      if (ctl_stp) begin
        state <= idle;
      end else if (ev_acq) begin
        state   <= pre;
        sts_trg <= 1'b0;
        sts_pre <= '0;
        sts_pst <= '0;
      end else begin
        case (state)
          pre: begin
            if (xfer) sts_pre <= sts_pre + 1'b1;
            if (sts_pre >= cfg_pre) state <= armed;  // pre-trigger filled
          end
          armed: begin
            if (xfer) sts_pre <= sts_pre + 1'b1;  // still pre-trigger data
            if (ev_trg) begin
              state   <= post;
              sts_trg <= 1'b1;
            end
          end
          post: begin
            if (xfer) sts_pst <= sts_pst + 1'b1;
            if (ev_end) state <= idle;
          end
          default: ;
        endcase
      end
    end
  end

  // timestamps of start, trigger and stop
  always_ff @(posedge bus) begin
    if (reset) begin
      cts_acq <= '0;
      cts_trg <= '0;
      cts_stp <= '0;
    end else begin
      if (ev_acq) cts_acq <= cts;
      if (ev_trg) cts_trg <= cts;  // time of the trigger cycle
      if (ev_stp) cts_stp <= cts;
    end
  end

endmodule

`default_nettype wire

/* src/scope_dec_avg.sv */
`timescale 1ns/1ns
`default_nettype none

module scope_dec_avg (
  input  logic               bus,
  input  logic               reset,
  input  logic               ctl_rst,
  // configuration
  input  logic               cfg_avg,  // average instead of pick
  input  scope_pkg::dec_t    cfg_dec,  // group size minus one
  input  scope_pkg::shr_t    cfg_shr,
  // input stream
  input  scope_pkg::sample_t sti_data,
  input  logic               sti_valid,
  output logic               sti_ready,
  // output stream
  output scope_pkg::sample_t sto_data,
  output logic               sto_valid,
  input  logic               sto_ready
);

  import scope_pkg::*;

  dec_t cnt;   // position inside group
  acc_t acc;   // running group sum
  acc_t sum;   // sum including current sample
  acc_t avg;
  logic xfer;  // input accepted
  logic last;  // current sample closes the group

  // output register free or being drained
  assign sti_ready = ~sto_valid | sto_ready;
  assign xfer      = sti_valid & sti_ready;
  assign last      = (cnt == cfg_dec);

  assign sum = acc + acc_t'(sti_data);  // sign extended
  assign avg = sum >>> cfg_shr;

  ////////////////////////////////////////////////////////////
  // group counter and accumulator
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset || ctl_rst) begin
      cnt       <= '0;
      acc       <= '0;
      sto_valid <= 1'b0;
    end else begin
      if (sto_valid && sto_ready) begin
        sto_valid <= 1'b0;  // drained, may be reloaded below
      end
      if (xfer) begin
        if (last) begin
          cnt       <= '0;
          acc       <= '0;
          sto_valid <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
          acc <= sum;
        end
      end
    end
  end

  // output sample, loaded at group end
  always_ff @(posedge bus) begin
    if (xfer && last) begin
      sto_data <= cfg_avg ? sample_t'(avg) : sti_data;  // truncated average
    end
  end

endmodule

`default_nettype wire

/* src/scope_edge.sv */
`timescale 1ns/1ns
`default_nettype none

`include "scope_defs.svh"

module scope_edge (
  input  logic               bus,
  input  logic               reset,
  input  logic               ctl_rst,
  // configuration
  input  logic               cfg_edg,  // 0 rising, 1 falling
  input  scope_pkg::sample_t cfg_lvl,
  input  scope_pkg::sample_t cfg_hst,
  // monitored stream
  input  scope_pkg::sample_t str_data,
  input  logic               str_valid,
  input  logic               str_ready,
  // trigger pulse
  output logic               trg_out
);

  import scope_pkg::*;

  // one extra bit so level +/- hysteresis cannot wrap
  logic signed [`SCOPE_DW:0] lvl_lo;
  logic signed [`SCOPE_DW:0] lvl_hi;
  logic                      xfer;
  logic                      armed;
  logic                      arm;   // sample beyond hysteresis band
  logic                      fire;  // sample crossed the level

  assign xfer   = str_valid & str_ready;
  assign lvl_lo = cfg_lvl - cfg_hst;
  assign lvl_hi = cfg_lvl + cfg_hst;

  assign arm  = cfg_edg ? (str_data > lvl_hi) : (str_data < lvl_lo);
  assign fire = cfg_edg ? (str_data <= cfg_lvl) : (str_data >= cfg_lvl);

  ////////////////////////////////////////////////////////////
  // schmitt style detector
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset || ctl_rst) begin
      armed   <= 1'b0;
      trg_out <= 1'b0;
    end else begin
      trg_out <= 1'b0;  // single cycle pulse
      if (xfer) begin
        if (armed && fire) begin
          trg_out <= 1'b1;
          armed   <= 1'b0;  // rearm needs band exit
        end else if (arm) begin
          armed <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/scope_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "scope_defs.svh"

module scope_regs (
  input  logic                bus,
  input  logic                reset,
  // system bus
  input  logic                bus_wen,
  input  logic                bus_ren,
  input  scope_pkg::bus_addr_t bus_addr,
  input  scope_pkg::bus_data_t bus_wdata,
  output scope_pkg::bus_data_t bus_rdata,
  output logic                bus_ack,
  output logic                bus_err,
  // status
  input  logic                sts_acq,
  input  logic                sts_trg,
  input  scope_pkg::cnt_t     sts_pre,
  input  scope_pkg::cnt_t     sts_pst,
  input  scope_pkg::stamp_t   cts_acq,
  input  scope_pkg::stamp_t   cts_trg,
  input  scope_pkg::stamp_t   cts_stp,
  // control strobes
  output logic                ctl_rst,
  output logic                ctl_acq,
  output logic                ctl_stp,
  output logic                trg_swo,
  // configuration
  output scope_pkg::trg_t     cfg_trg,
  output scope_pkg::cnt_t     cfg_pre,
  output scope_pkg::cnt_t     cfg_pst,
  output scope_pkg::sample_t  cfg_lvl,
  output scope_pkg::sample_t  cfg_hst,
  output logic                cfg_edg,
  output logic                cfg_avg,
  output scope_pkg::dec_t     cfg_dec,
  output scope_pkg::shr_t     cfg_shr
);

  import scope_pkg::*;

  logic [`SCOPE_BAW-1:0] adr;  // decoded part of address
  logic                  ctl_wr;

  assign adr    = bus_addr[`SCOPE_BAW-1:0];
  assign ctl_wr = bus_wen & (adr == 'h00);

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      bus_ack <= 1'b0;
    end else begin
      bus_ack <= bus_wen | bus_ren;  // fixed one cycle latency
    end
  end

  assign bus_err = 1'b0;  // no error responses

  // strobes in the write cycle itself
  assign ctl_rst = ctl_wr & bus_wdata[0];
  assign trg_swo = ctl_wr & bus_wdata[1];
  assign ctl_acq = ctl_wr & bus_wdata[2];
  assign ctl_stp = ctl_wr & bus_wdata[3];

  ////////////////////////////////////////////////////////////
  // configuration writes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      cfg_trg <= '0;
      cfg_pre <= '0;
      cfg_pst <= '0;
      cfg_lvl <= '0;
      cfg_hst <= '0;
      cfg_edg <= 1'b0;
      cfg_avg <= 1'b0;
      cfg_dec <= '0;
      cfg_shr <= '0;
    end else if (bus_wen) begin
      case (adr)
        'h08: cfg_trg <= bus_wdata[`SCOPE_TN-1:0];
        'h10: cfg_pre <= bus_wdata[`SCOPE_CW-1:0];
        'h14: cfg_pst <= bus_wdata[`SCOPE_CW-1:0];
        'h50: cfg_lvl <= bus_wdata[`SCOPE_DW-1:0];
        'h54: cfg_hst <= bus_wdata[`SCOPE_DW-1:0];
        'h58: cfg_edg <= bus_wdata[0];  // 0 rising, 1 falling
        'h60: cfg_avg <= bus_wdata[0];
        'h64: cfg_dec <= bus_wdata[`SCOPE_DCW-1:0];
        'h68: cfg_shr <= bus_wdata[`SCOPE_DSW-1:0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // readback, valid with ack
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (bus_ren) begin
      case (adr)
        'h00: bus_rdata <= bus_data_t'({~sts_acq, sts_acq, sts_trg, 1'b0});
        'h08: bus_rdata <= bus_data_t'(cfg_trg);
        'h10: bus_rdata <= bus_data_t'(cfg_pre);
        'h14: bus_rdata <= bus_data_t'(cfg_pst);
        'h18: bus_rdata <= bus_data_t'(sts_pre);
        'h1c: bus_rdata <= bus_data_t'(sts_pst);
        'h20: bus_rdata <= cts_acq[31:0];
        'h24: bus_rdata <= cts_acq[`SCOPE_TW-1:32];
        'h28: bus_rdata <= cts_trg[31:0];
        'h2c: bus_rdata <= cts_trg[`SCOPE_TW-1:32];
        'h30: bus_rdata <= cts_stp[31:0];
        'h34: bus_rdata <= cts_stp[`SCOPE_TW-1:32];
        'h50: bus_rdata <= bus_data_t'(unsigned'(cfg_lvl));  // zero filled
        'h54: bus_rdata <= bus_data_t'(unsigned'(cfg_hst));
        'h58: bus_rdata <= bus_data_t'(cfg_edg);
        'h60: bus_rdata <= bus_data_t'(cfg_avg);
        'h64: bus_rdata <= bus_data_t'(cfg_dec);
        'h68: bus_rdata <= bus_data_t'(cfg_shr);
        default: bus_rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/scope_top.sv */
`timescale 1ns/1ns
`default_nettype none

module scope_top (
  input  logic                 bus,
  input  logic                 reset,
  // system bus
  input  logic                 bus_wen,
  input  logic                 bus_ren,
  input  scope_pkg::bus_addr_t bus_addr,
  input  scope_pkg::bus_data_t bus_wdata,
  output scope_pkg::bus_data_t bus_rdata,
  output logic                 bus_ack,
  output logic                 bus_err,
  // sample input
  input  scope_pkg::sample_t   sti_data,
  input  logic                 sti_valid,
  output logic                 sti_ready,
  // captured output
  output scope_pkg::sample_t   sto_data,
  output logic                 sto_last,
  output logic                 sto_valid,
  input  logic                 sto_ready,
  // time and triggers
  input  scope_pkg::stamp_t    cts,
  input  logic [1:0]           trg_ext,
  output logic                 trg_swo,  // software trigger strobe
  output logic                 trg_out,  // edge detector pulse
  // interrupts
  output logic                 irq_trg,
  output logic                 irq_stp
);

  import scope_pkg::*;

  logic    ctl_rst, ctl_acq, ctl_stp;
  logic    cfg_edg, cfg_avg;
  trg_t    cfg_trg, trg_src;
  cnt_t    cfg_pre, cfg_pst, sts_pre, sts_pst;
  sample_t cfg_lvl, cfg_hst;
  dec_t    cfg_dec;
  shr_t    cfg_shr;
  logic    sts_acq, sts_trg;
  stamp_t  cts_acq, cts_trg, cts_stp;
  // decimated stream
  sample_t std_data;
  logic    std_valid, std_ready;

  assign trg_src = {trg_ext, trg_out, trg_swo};

  scope_regs regs_i (.*);

  scope_dec_avg dec_avg_i (
    .bus, .reset, .ctl_rst, .cfg_avg, .cfg_dec, .cfg_shr,
    .sti_data, .sti_valid, .sti_ready,
    .sto_data (std_data), .sto_valid (std_valid), .sto_ready (std_ready)
  );

  // monitors the decimated handshake only
  scope_edge edge_i (
    .bus, .reset, .ctl_rst, .cfg_edg, .cfg_lvl, .cfg_hst,
    .str_data (std_data), .str_valid (std_valid), .str_ready (std_ready),
    .trg_out
  );

  scope_acq acq_i (
    .bus, .reset, .ctl_rst, .ctl_acq, .ctl_stp, .cfg_trg, .trg_src,
    .cfg_pre, .cfg_pst, .cts,
    .sti_data (std_data), .sti_valid (std_valid), .sti_ready (std_ready),
    .sto_data, .sto_last, .sto_valid, .sto_ready,
    .sts_acq, .sts_trg, .sts_pre, .sts_pst, .cts_acq, .cts_trg, .cts_stp,
    .irq_trg, .irq_stp
  );

endmodule

`default_nettype wire

/* tb/scope_props.sv */
`timescale 1ns/1ns
`default_nettype none

module scope_props (
  input logic               bus,
  input logic               reset,
  input logic               ctl_rst,
  input logic               ctl_acq,
  input logic               ctl_stp,
  input scope_pkg::sample_t sto_data,
  input logic               sto_valid,
  input logic               sto_ready,
  input logic               sto_last,
  input logic               irq_trg,
  input logic               irq_stp
);

  // a waiting sample holds until taken, unless the run is cut short
  hold_a: assert property (@(posedge bus) disable iff (reset)
    sto_valid && !sto_ready && !ctl_stp && !ctl_rst |=> sto_valid && $stable(sto_data))
    else $error("output sample changed or vanished while waiting for ready");

  trg_pulse_a: assert property (@(posedge bus) disable iff (reset)
    irq_trg |=> !irq_trg)
    else $error("trigger interrupt longer than one cycle");

  stp_pulse_a: assert property (@(posedge bus) disable iff (reset)
    irq_stp |=> !irq_stp)
    else $error("stop interrupt longer than one cycle");

  last_a: assert property (@(posedge bus) disable iff (reset)
    sto_last && sto_ready && !ctl_acq |=> !sto_valid)  // run over after the last sample
    else $error("output still valid after the last sample");

endmodule

bind scope_acq scope_props props_i (
  .bus       (bus),
  .reset     (reset),
  .ctl_rst   (ctl_rst),
  .ctl_acq   (ctl_acq),
  .ctl_stp   (ctl_stp),
  .sto_data  (sto_data),
  .sto_valid (sto_valid),
  .sto_ready (sto_ready),
  .sto_last  (sto_last),
  .irq_trg   (irq_trg),
  .irq_stp   (irq_stp)
);

`default_nettype wire

/* tb/scope_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module scope_tb;

  import scope_pkg::*;

  logic      bus;
  logic      reset;
  logic      bus_wen, bus_ren, bus_ack, bus_err;
  bus_addr_t bus_addr;
  bus_data_t bus_wdata, bus_rdata;
  sample_t   sti_data, sto_data;
  logic      sti_valid, sti_ready, sto_valid, sto_ready, sto_last;
  stamp_t    cts;
  logic [1:0] trg_ext;
  logic      trg_swo, trg_out, irq_trg, irq_stp;

  int        errors, checks;
  sample_t   stim[$];      // samples for send_samples
  sample_t   got[$];       // transferred output samples
  logic      got_last[$];
  logic      saw_last;
  int        trg_cnt, trg_idx, irq_trg_cnt, irq_stp_cnt, swo_cnt;
  stamp_t    wr_cts;       // cts in the cycle of the last write strobe

  int reg_adr [9] = '{'h08, 'h10, 'h14, 'h50, 'h54, 'h58, 'h60, 'h64, 'h68};
  int reg_wid [9] = '{4, 32, 32, 14, 14, 1, 1, 17, 4};
  // rising edge pattern, lvl 500 hst 50, fires on index 9
  int edge_pat [15] = '{600, 540, 470, 520, 460, 530, 400, 470, 480, 510,
                        490, 505, 495, 540, 460};

  scope_top scope_top_i (.*);

  always #2 bus = ~bus;

  always @(posedge bus) begin
    #1;
    cts = cts + 1;  // free running cycle count
  end

  ////////////////////////////////////////////////////////////
  // output monitor, mid cycle
  ////////////////////////////////////////////////////////////

  always @(negedge bus) begin
    if (!reset) begin
      if (trg_out) begin
        trg_cnt++;
        if (trg_idx < 0) trg_idx = got.size() - 1;  // sample before the pulse
      end
      if (trg_swo) swo_cnt++;
      if (irq_trg) irq_trg_cnt++;
      if (irq_stp) irq_stp_cnt++;
      if (sto_valid && sto_ready) begin
        got.push_back(sto_data);
        got_last.push_back(sto_last);
        if (sto_last) saw_last = 1'b1;
      end
    end
  end

  task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: expected 0x%h, actual 0x%h", name, exp, act);
    end
  endtask

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus and stream tasks, entered 1 ns after a rising edge
  ////////////////////////////////////////////////////////////

  task automatic wait_ack();
    int cyc;
    cyc = 0;
    while (!bus_ack && cyc < 8) begin
      @(posedge bus);
      #1;
      cyc++;
    end
    if (!bus_ack) begin
      errors++;
      $display("timeout, no bus ack after the strobe");
    end else begin
      check_bit("bus ack one cycle after strobe", 1'b1, cyc == 0);
    end
  endtask

  task automatic bus_write(input bus_data_t adr, input bus_data_t dat);
    bus_addr  = adr;
    bus_wdata = dat;
    bus_wen   = 1'b1;
    @(negedge bus);
    wr_cts = cts;  // value the strobe edge sees
    @(posedge bus);
    #1;
    bus_wen = 1'b0;
    wait_ack();
  endtask

  task automatic bus_read(input bus_data_t adr, output bus_data_t dat);
    bus_addr = adr;
    bus_ren  = 1'b1;
    @(posedge bus);
    #1;
    bus_ren = 1'b0;
    wait_ack();
    dat = bus_rdata;
  endtask

  task automatic send_samples();
    int cyc;
    bit done;
    foreach (stim[i]) begin
      sti_data  = stim[i];
      sti_valid = 1'b1;
      cyc  = 0;
      done = 1'b0;
      while (!done && cyc < 200) begin
        @(negedge bus);
        done = sti_ready;  // transfer on the coming edge
        @(posedge bus);
        #1;
        cyc++;
      end
      if (!done) begin
        errors++;
        $display("timeout, input sample %0d never accepted", i);
      end
    end
    sti_valid = 1'b0;
  endtask

  // run sto_ready until n samples or the last flag arrived
  task automatic collect(input bit stall, input int n);
    int cyc;
    cyc = 0;
    while (got.size() < n && !saw_last && cyc < 4000) begin
      sto_ready = stall ? (($urandom % 3) != 0) : 1'b1;
      @(posedge bus);
      #1;
      cyc++;
    end
    sto_ready = 1'b1;
    if (got.size() < n && !saw_last) begin
      errors++;
      $display("timeout, only %0d of %0d output samples arrived", got.size(), n);
    end
  endtask

  task automatic clear_capture();
    got.delete();
    got_last.delete();
    saw_last    = 1'b0;
    trg_cnt     = 0;
    trg_idx     = -1;
    irq_trg_cnt = 0;
    irq_stp_cnt = 0;
    swo_cnt     = 0;
  endtask

  task automatic setup(input bit avg, input int dec, input int shr, input int trg,
                       input int pre, input int pst);
    bus_write('h60, bus_data_t'(avg));
    bus_write('h64, bus_data_t'(dec));
    bus_write('h68, bus_data_t'(shr));
    bus_write('h08, bus_data_t'(trg));
    bus_write('h10, bus_data_t'(pre));
    bus_write('h14, bus_data_t'(pst));
    bus_write('h00, 'h1);  // ctl_rst, clean pipeline
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic reg_test();
    bus_data_t rd, pat, msk;
    bus_read('h00, rd);
    check_data("status after reset", 'h8, rd);  // idle, no trigger
    for (int p = 0; p < 2; p++) begin
      pat = p ? 32'h3c3c_a5a5 : 32'hc3c3_5a5a;
      for (int i = 0; i < 9; i++) bus_write(reg_adr[i], pat ^ bus_data_t'(i));
      for (int i = 0; i < 9; i++) begin
        msk = bus_data_t'((64'd1 << reg_wid[i]) - 64'd1);
        bus_read(reg_adr[i], rd);
        check_data($sformatf("reg 0x%0h", reg_adr[i]), (pat ^ bus_data_t'(i)) & msk, rd);
      end
    end
    bus_read('h04, rd);
    check_data("unmapped 0x04", '0, rd);
    bus_read('h40, rd);
    check_data("unmapped 0x40", '0, rd);
    bus_read('h7c, rd);
    check_data("unmapped 0x7c", '0, rd);
    check_bit("bus err", 1'b0, bus_err);
  endtask

  task automatic dec_test(input string name, input bit avg, input int base, input int step);
    int sum;
    sample_t exp;
    setup(avg, 3, 2, 0, 0, 1);
    clear_capture();
    bus_write('h00, 'h4);  // start, never triggers
    stim.delete();
    for (int i = 0; i < 16; i++) stim.push_back(sample_t'(base + step * i));
    fork
      send_samples();
      collect(1'b0, 4);
    join
    check_data({name, " count"}, 4, bus_data_t'(got.size()));
    for (int k = 0; k < 4; k++) begin
      sum = 0;
      for (int j = 0; j < 4; j++) sum += base + step * (4 * k + j);
      exp = avg ? sample_t'(sum >>> 2) : sample_t'(base + step * (4 * k + 3));
      check_sample($sformatf("%s out %0d", name, k), exp, got[k]);
    end
    bus_write('h00, 'h8);
  endtask

  task automatic edge_test(input string name, input bit neg);
    setup(1'b0, 0, 0, 'b0010, 0, 100);  // edge detector selected
    bus_write('h50, 500);
    bus_write('h54, 50);
    bus_write('h58, bus_data_t'(neg));
    bus_write('h00, 'h1);
    clear_capture();
    bus_write('h00, 'h4);
    stim.delete();
    foreach (edge_pat[i]) stim.push_back(sample_t'(neg ? 1000 - edge_pat[i] : edge_pat[i]));
    fork
      send_samples();
      collect(1'b0, 15);
    join
    check_data({name, " pulses"}, 1, bus_data_t'(trg_cnt));
    check_data({name, " firing sample"}, 9, bus_data_t'(trg_idx));
    check_data({name, " irq_trg"}, 1, bus_data_t'(irq_trg_cnt));
    bus_write('h00, 'h8);
  endtask

  task automatic acq_run(input string name, input bit stall);
    bus_data_t rd, pre_cnt;
    stamp_t t_trg;
    sample_t exp;
    setup(1'b0, 0, 0, 'b0001, 6, 5);
    clear_capture();
    bus_write('h00, 'h4);
    stim.delete();
    for (int i = 0; i < 8; i++) stim.push_back(sample_t'(200 + 3 * i));
    fork
      send_samples();
      collect(stall, 8);
    join
    bus_write('h00, 'h2);  // software trigger
    t_trg = wr_cts;
    stim.delete();
    for (int i = 8; i < 13; i++) stim.push_back(sample_t'(200 + 3 * i));
    fork
      send_samples();
      collect(stall, 13);
    join
    bus_read('h18, pre_cnt);
    check_data({name, " sts_pre"}, 8, pre_cnt);  // 6 pre plus 2 armed
    check_data({name, " count"}, 13, bus_data_t'(got.size()));  // 6 pre, 2 armed, 5 post
    for (int i = 0; i < got.size(); i++) begin
      exp = sample_t'(200 + 3 * i);
      check_sample($sformatf("%s sample %0d", name, i), exp, got[i]);
      check_bit($sformatf("%s last %0d", name, i), i == got.size() - 1, got_last[i]);
    end
    bus_read('h00, rd);
    check_data({name, " status"}, 'ha, rd);  // idle, triggered
    bus_read('h1c, rd);
    check_data({name, " sts_pst"}, 5, rd);
    bus_read('h28, rd);
    check_data({name, " cts_trg low"}, t_trg[31:0], rd);
    bus_read('h2c, rd);
    check_data({name, " cts_trg high"}, t_trg[63:32], rd);
    check_data({name, " trg_swo"}, 1, bus_data_t'(swo_cnt));
    check_data({name, " irq_trg"}, 1, bus_data_t'(irq_trg_cnt));
    check_data({name, " irq_stp"}, 1, bus_data_t'(irq_stp_cnt));
  endtask

  task automatic abort_run();
    bus_data_t rd;
    clear_capture();
    bus_write('h00, 'h4);
    stim.delete();
    for (int i = 0; i < 3; i++) stim.push_back(sample_t'(-50 * i));
    fork
      send_samples();
      collect(1'b0, 3);
    join
    bus_write('h00, 'h8);  // stop before the trigger
    bus_read('h00, rd);
    check_data("abort status", 'h8, rd);
    bus_read('h1c, rd);
    check_data("abort sts_pst", 0, rd);
    check_data("abort count", 3, bus_data_t'(got.size()));
    check_bit("abort last", 1'b0, saw_last);
    check_data("abort irq_trg", 0, bus_data_t'(irq_trg_cnt));
    check_data("abort irq_stp", 1, bus_data_t'(irq_stp_cnt));
  endtask

  initial begin
    void'($urandom(32'he5c23aed));
    errors    = 0;
    checks    = 0;
    bus       = 1'b0;
    reset     = 1'b1;
    bus_wen   = 1'b0;
    bus_ren   = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    sti_data  = '0;
    sti_valid = 1'b0;
    sto_ready = 1'b1;
    cts       = '0;
    trg_ext   = '0;
    clear_capture();
    repeat (2) @(posedge bus);
    #1;
    reset = 1'b0;
    reg_test();
    dec_test("decimate", 1'b0, 100, 7);
    dec_test("average up", 1'b1, 1000, 37);
    dec_test("average down", 1'b1, -2000, -53);
    edge_test("edge rising", 1'b0);
    edge_test("edge falling", 1'b1);
    acq_run("acq", 1'b0);
    abort_run();
    acq_run("acq stalled", 1'b1);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
